//--- rv_ls_pkg.sv
package rv_ls_pkg;

    localparam int XLEN = 64;

    // ************************************************************
    // Major opcodes, instruction bits 6 to 2
    // ************************************************************
    localparam logic [4:0] OPC_LOAD     = 5'b00000;
    localparam logic [4:0] OPC_OPIMM    = 5'b00100;
    localparam logic [4:0] OPC_AUIPC    = 5'b00101;
    localparam logic [4:0] OPC_OPIMM32  = 5'b00110;
    localparam logic [4:0] OPC_STORE    = 5'b01000;
    localparam logic [4:0] OPC_OP       = 5'b01100;
    localparam logic [4:0] OPC_LUI      = 5'b01101;
    localparam logic [4:0] OPC_OP32     = 5'b01110;
    localparam logic [4:0] OPC_JALR     = 5'b11001;
    localparam logic [4:0] OPC_JAL      = 5'b11011;
    localparam logic [4:0] OPC_SYSTEM   = 5'b11100;

    // Memory funct3, low bits give size, bit 2 means zero extend
    localparam logic [2:0] MEMOP_LB     = 3'b000;
    localparam logic [2:0] MEMOP_LH     = 3'b001;
    localparam logic [2:0] MEMOP_LW     = 3'b010;
    localparam logic [2:0] MEMOP_LD     = 3'b011;
    localparam logic [2:0] MEMOP_LBU    = 3'b100;
    localparam logic [2:0] MEMOP_LHU    = 3'b101;
    localparam logic [2:0] MEMOP_LWU    = 3'b110;

    // SYSTEM funct3 for the CSR group
    localparam logic [2:0] CSR_OP_RW    = 3'b001;
    localparam logic [2:0] CSR_OP_RS    = 3'b010;
    localparam logic [2:0] CSR_OP_RC    = 3'b011;

    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;

    localparam logic [XLEN-1:0] TRAP_CAUSE = 64'd11;   // Environment call from M-mode

    // ************************************************************
    // Instruction word views
    // ************************************************************
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } itype_t;

    typedef struct packed {
        logic [6:0]  imm_hi;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_lo;
        logic [6:0]  opcode;
    } stype_t;

    typedef union packed {
        itype_t itype;   // Loads and CSR instructions
        stype_t stype;   // Stores
    } instr_u;

    typedef struct packed {
        logic            rden;
        logic            wren;
        logic [2:0]      memop;
        logic [XLEN-1:0] wr_data;   // Unshifted store data
    } mem_req_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic            rd_en;
        logic            wr_en;
        logic [XLEN-1:0] wr_data;
        logic [7:0]      wr_mask;
        logic [2:0]      wr_size;
        logic [2:0]      rd_size;
    } sram_req_t;

    typedef struct packed {
        logic            rd_data_valid;
        logic            wr_data_ok;
        logic [XLEN-1:0] rd_data;
    } sram_rsp_t;

    function automatic logic [4:0] major_op(input instr_u instr);
        return instr.itype.opcode[6:2];
    endfunction

endpackage

//--- ls_ctr.sv
module ls_ctr
    import rv_ls_pkg::*;
(
    input  logic            valid_i,
    input  instr_u          instr_i,
    input  instr_u          instr_last_i,
    input  logic [XLEN-1:0] rs2_i,
    input  logic [XLEN-1:0] wb_data_i,
    output mem_req_t        mem_req_o
);

    logic [4:0] opc;
    logic [4:0] opc_last;
    logic [4:0] rd_last;
    logic       last_writes_rd;
    logic       fwd_hit;

    assign opc      = major_op(instr_i);
    assign opc_last = major_op(instr_last_i);
    assign rd_last  = instr_last_i.itype.rd;

    // ************************************************************
    // Does the previous instruction write a register
    // ************************************************************
    always_comb begin
        case (opc_last)
            OPC_LOAD,
            OPC_OPIMM,
            OPC_OPIMM32,
            OPC_OP,
            OPC_OP32,
            OPC_LUI,
            OPC_AUIPC,
            OPC_JAL,
            OPC_JALR,
            OPC_SYSTEM: last_writes_rd = 1'b1;
            default:    last_writes_rd = 1'b0;
        endcase
    end

    // Store rs2 produced by the instruction now in write-back
    assign fwd_hit = last_writes_rd
                  && (rd_last != 5'd0)
                  && (rd_last == instr_i.stype.rs2);

    // ************************************************************
    // Memory request toward lsu
    // ************************************************************
    always_comb begin
        mem_req_o.rden    = valid_i && (opc == OPC_LOAD);
        mem_req_o.wren    = valid_i && (opc == OPC_STORE);
        mem_req_o.memop   = instr_i.itype.funct3;   // Same bits in both views
        mem_req_o.wr_data = fwd_hit ? wb_data_i : rs2_i;
    end

endmodule

//--- lsu.sv
module lsu
    import rv_ls_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            valid_i,
    input  mem_req_t        mem_req_i,
    input  logic [XLEN-1:0] addr_i,
    input  logic [XLEN-1:0] alures_i,
    input  sram_rsp_t       sram_rsp_i,
    output sram_req_t       sram_req_o,
    output logic            ls_not_ok_o,
    output logic [XLEN-1:0] ls_res_o,
    output logic            res_valid_o
);

    logic [2:0]      byte_off;
    logic [5:0]      bit_off;
    logic [1:0]      size;
    logic [7:0]      size_mask;
    logic            rd_wait;
    logic            wr_wait;
    logic            done;
    logic [XLEN-1:0] rd_shift;
    logic [XLEN-1:0] load_val;

    assign byte_off = addr_i[2:0];
    assign bit_off  = {byte_off, 3'b000};
    assign size     = mem_req_i.memop[1:0];   // log2 of access bytes

    // ************************************************************
    // Byte lanes and SRAM request
    // ************************************************************
    always_comb begin
        case (size)
            2'd0:    size_mask = 8'h01;
            2'd1:    size_mask = 8'h03;
            2'd2:    size_mask = 8'h0f;
            default: size_mask = 8'hff;
        endcase
    end

    // Request is held as long as the stage input is held
    always_comb begin
        sram_req_o.addr    = {addr_i[XLEN-1:3], 3'b000};
        sram_req_o.rd_en   = mem_req_i.rden;
        sram_req_o.wr_en   = mem_req_i.wren;
        sram_req_o.wr_data = mem_req_i.wr_data << bit_off;
        sram_req_o.wr_mask = size_mask << byte_off;
        sram_req_o.wr_size = {1'b0, size};
        sram_req_o.rd_size = {1'b0, size};
    end

    assign rd_wait     = mem_req_i.rden && !sram_rsp_i.rd_data_valid;
    assign wr_wait     = mem_req_i.wren && !sram_rsp_i.wr_data_ok;
    assign ls_not_ok_o = rd_wait || wr_wait;
    assign done        = valid_i && !ls_not_ok_o;   // Instruction leaves at this edge

    // ************************************************************
    // Load extraction and extension
    // ************************************************************
    assign rd_shift = sram_rsp_i.rd_data >> bit_off;

    always_comb begin
        case (mem_req_i.memop)
            MEMOP_LB:  load_val = {{56{rd_shift[7]}}, rd_shift[7:0]};
            MEMOP_LH:  load_val = {{48{rd_shift[15]}}, rd_shift[15:0]};
            MEMOP_LW:  load_val = {{32{rd_shift[31]}}, rd_shift[31:0]};
            MEMOP_LD:  load_val = rd_shift;
            MEMOP_LBU: load_val = {56'd0, rd_shift[7:0]};
            MEMOP_LHU: load_val = {48'd0, rd_shift[15:0]};
            MEMOP_LWU: load_val = {32'd0, rd_shift[31:0]};
            default:   load_val = rd_shift;
        endcase
    end

    // ************************************************************
    // Result register
    // ************************************************************
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= done && !mem_req_i.wren;   // Stores give no result
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            ls_res_o <= mem_req_i.rden ? load_val : alures_i;
        end
    end

endmodule

//--- csr_unit.sv
module csr_unit
    import rv_ls_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_MTVEC = '0
) (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            valid_i,
    input  logic            stall_i,
    input  logic [XLEN-1:0] pc_i,
    input  instr_u          instr_i,
    input  logic [XLEN-1:0] csr_wr_data_i,
    input  logic            trap_i,
    output logic [XLEN-1:0] csr_data_o,
    output logic [XLEN-1:0] mtvec_o,
    output logic [XLEN-1:0] mepc_o
);

    logic [2:0]      funct3;
    logic [11:0]     csr_addr;
    logic            is_csr;
    logic            csr_we;
    logic            trap_we;
    logic [XLEN-1:0] csr_old;
    logic [XLEN-1:0] csr_new;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;
    logic [XLEN-1:0] mscratch_q;

    assign funct3   = instr_i.itype.funct3;
    assign csr_addr = instr_i.itype.imm;
    assign is_csr   = valid_i && (major_op(instr_i) == OPC_SYSTEM)
                   && (funct3 inside {CSR_OP_RW, CSR_OP_RS, CSR_OP_RC});

    // ************************************************************
    // Read and modify
    // ************************************************************
    always_comb begin
        case (csr_addr)
            CSR_MTVEC:    csr_old = mtvec_q;
            CSR_MEPC:     csr_old = mepc_q;
            CSR_MCAUSE:   csr_old = mcause_q;
            CSR_MSCRATCH: csr_old = mscratch_q;
            default:      csr_old = '0;
        endcase
    end

    always_comb begin
        case (funct3)
            CSR_OP_RS: csr_new = csr_old | csr_wr_data_i;
            CSR_OP_RC: csr_new = csr_old & ~csr_wr_data_i;
            default:   csr_new = csr_wr_data_i;
        endcase
    end

    assign csr_data_o = is_csr ? csr_old : '0;

    // Set and clear with rs1 = x0 only read
    assign csr_we  = is_csr && !stall_i && !trap_i
                  && ((funct3 == CSR_OP_RW) || (instr_i.itype.rs1 != 5'd0));
    assign trap_we = valid_i && trap_i && !stall_i;

    // ************************************************************
    // CSR registers
    // ************************************************************
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mtvec_q    <= RESET_MTVEC;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mscratch_q <= '0;
        end else if (trap_we) begin
            mepc_q     <= pc_i;
            mcause_q   <= TRAP_CAUSE;
        end else if (csr_we) begin
            case (csr_addr)
                CSR_MTVEC:    mtvec_q    <= csr_new;
                CSR_MEPC:     mepc_q     <= csr_new;
                CSR_MCAUSE:   mcause_q   <= csr_new;
                CSR_MSCRATCH: mscratch_q <= csr_new;
                default:      ;   // Unknown address ignored
            endcase
        end
    end

    assign mtvec_o = mtvec_q;
    assign mepc_o  = mepc_q;

endmodule

//--- ls_stage.sv
module ls_stage
    import rv_ls_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_MTVEC = 64'h0000_0000_8000_0000
) (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            valid_i,
    input  logic [XLEN-1:0] pc_i,
    input  instr_u          instr_i,
    input  logic [XLEN-1:0] alures_i,
    input  logic [XLEN-1:0] rs2_i,
    input  instr_u          instr_last_i,
    input  logic [XLEN-1:0] wb_data_i,
    input  logic            trap_i,
    input  sram_rsp_t       sram_rsp_i,
    output logic [XLEN-1:0] ls_res_o,
    output logic            res_valid_o,
    output logic [XLEN-1:0] csr_data_o,
    output logic [XLEN-1:0] mtvec_o,
    output logic [XLEN-1:0] mepc_o,
    output logic            ls_not_ok_o,
    output sram_req_t       sram_req_o
);

    mem_req_t mem_req;

    ls_ctr ls_ctr_inst (
        .valid_i      (valid_i),
        .instr_i      (instr_i),
        .instr_last_i (instr_last_i),
        .rs2_i        (rs2_i),
        .wb_data_i    (wb_data_i),
        .mem_req_o    (mem_req)
    );

    lsu lsu_inst (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .valid_i      (valid_i),
        .mem_req_i    (mem_req),
        .addr_i       (alures_i),   // ALU result is the effective address
        .alures_i     (alures_i),
        .sram_rsp_i   (sram_rsp_i),
        .sram_req_o   (sram_req_o),
        .ls_not_ok_o  (ls_not_ok_o),
        .ls_res_o     (ls_res_o),
        .res_valid_o  (res_valid_o)
    );

    csr_unit #(
        .RESET_MTVEC  (RESET_MTVEC)
    ) csr_unit_inst (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .valid_i      (valid_i),
        .stall_i      (ls_not_ok_o),   // Write once, at completion
        .pc_i         (pc_i),
        .instr_i      (instr_i),
        .csr_wr_data_i(alures_i),
        .trap_i       (trap_i),
        .csr_data_o   (csr_data_o),
        .mtvec_o      (mtvec_o),
        .mepc_o       (mepc_o)
    );

endmodule

//--- tb_sram_model.sv
module tb_sram_model
    import rv_ls_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    input  sram_req_t sram_req_i,
    output sram_rsp_t sram_rsp_o
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [XLEN-1:0] mem [0:255];
    logic [1:0]      lat_q;   // Cycles to wait for the current request
    logic [1:0]      cnt_q;
    logic [7:0]      idx;
    logic            active;
    logic            answer;

    assign idx    = sram_req_i.addr[10:3];
    assign active = sram_req_i.rd_en || sram_req_i.wr_en;
    assign answer = active && (cnt_q == lat_q);   // Latency 0 answers in the first cycle

    always_comb begin
        sram_rsp_o.rd_data_valid = answer && sram_req_i.rd_en;
        sram_rsp_o.wr_data_ok    = answer && sram_req_i.wr_en;
        sram_rsp_o.rd_data       = mem[idx];
    end

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {32'(i) ^ 32'h5a5a_0f0f, ~32'(i)};
        end
    end

    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lat_q <= 2'd0;
            cnt_q <= 2'd0;
        end else if (answer) begin
            cnt_q <= 2'd0;
            lat_q <= 2'($urandom % 4);
            for (int b = 0; b < 8; b++) begin
                if (sram_req_i.wr_en && sram_req_i.wr_mask[b]) begin
                    mem[idx][8*b +: 8] <= sram_req_i.wr_data[8*b +: 8];
                end
            end
        end else if (active) begin
            cnt_q <= cnt_q + 2'd1;
        end
    end

endmodule

//--- tb_ls_stage.sv
module tb_ls_stage
    import rv_ls_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int              PERIOD      = 20;
    localparam logic [XLEN-1:0] RESET_MTVEC = 64'h0000_0000_8000_0000;   // DUT default
    localparam logic [31:0]     NOP         = 32'h0000_0013;             // addi x0, x0, 0
    localparam logic [31:0]     ADDI_X7     = {12'd0, 5'd1, 3'd0, 5'd7, OPC_OPIMM, 2'b11};

    typedef struct packed {
        logic [31:0]     instr;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] alures;
        logic [XLEN-1:0] rs2;
        logic [31:0]     last;
        logic [XLEN-1:0] wb_data;
        logic            trap;
        logic            exp_rd;
        logic            exp_wr;
        logic [7:0]      exp_mask;
        logic            exp_valid;
        logic [XLEN-1:0] exp_res;
        logic [XLEN-1:0] exp_csr;
        logic [XLEN-1:0] exp_mtvec;
        logic [XLEN-1:0] exp_mepc;
    } entry_t;

    logic            clk;
    logic            arst_n;
    logic            valid;
    logic [XLEN-1:0] pc;
    instr_u          instr;
    logic [XLEN-1:0] alures;
    logic [XLEN-1:0] rs2;
    instr_u          instr_last;
    logic [XLEN-1:0] wb_data;
    logic            trap;
    sram_req_t       sram_req;
    sram_rsp_t       sram_rsp;
    logic [XLEN-1:0] ls_res;
    logic            res_valid;
    logic [XLEN-1:0] csr_data;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic            ls_not_ok;

    entry_t          table_q [$];
    logic            table_ready;
    logic [7:0]      shadow [0:255];   // Expected memory bytes, low address byte as index
    logic [XLEN-1:0] ref_mtvec;
    logic [XLEN-1:0] ref_mepc;
    logic [XLEN-1:0] ref_mcause;
    logic [XLEN-1:0] ref_mscratch;
    logic [XLEN-1:0] next_pc;

    ls_stage ls_stage_inst (
        .clk(clk), .arst_n_i(arst_n), .valid_i(valid), .pc_i(pc), .instr_i(instr),
        .alures_i(alures), .rs2_i(rs2), .instr_last_i(instr_last), .wb_data_i(wb_data),
        .trap_i(trap), .sram_rsp_i(sram_rsp), .ls_res_o(ls_res), .res_valid_o(res_valid),
        .csr_data_o(csr_data), .mtvec_o(mtvec), .mepc_o(mepc), .ls_not_ok_o(ls_not_ok),
        .sram_req_o(sram_req)
    );

    tb_sram_model sram_inst (
        .clk(clk), .arst_n_i(arst_n), .sram_req_i(sram_req), .sram_rsp_o(sram_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // ************************************************************
    // Compare tasks
    // ************************************************************
    task automatic report_mismatch(input string name, input logic [XLEN-1:0] exp,
                                   input logic [XLEN-1:0] act);
        $display("ERR %s expected %h actual %h", name, exp, act);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic compare_xlen(input string name, input logic [XLEN-1:0] exp,
                                input logic [XLEN-1:0] act);
        if (act !== exp) begin
            report_mismatch(name, exp, act);
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_mismatch(name, 64'(exp), 64'(act));
        end
    endtask

    task automatic compare_mask(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            report_mismatch(name, 64'(exp), 64'(act));
        end
    endtask

    task automatic compare_size(input string name, input logic [2:0] exp, input logic [2:0] act);
        if (act !== exp) begin
            report_mismatch(name, 64'(exp), 64'(act));
        end
    endtask

    // ************************************************************
    // Reference model used to fill in expected values
    // ************************************************************
    function automatic bit writes_rd(input logic [4:0] opc);
        return opc inside {OPC_LOAD, OPC_OPIMM, OPC_OPIMM32, OPC_OP, OPC_OP32, OPC_LUI,
                           OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_SYSTEM};
    endfunction

    function automatic logic [XLEN-1:0] read_csr(input logic [11:0] addr);
        case (addr)
            CSR_MTVEC:    return ref_mtvec;
            CSR_MEPC:     return ref_mepc;
            CSR_MCAUSE:   return ref_mcause;
            CSR_MSCRATCH: return ref_mscratch;
            default:      return '0;
        endcase
    endfunction

    task automatic write_csr(input logic [11:0] addr, input logic [XLEN-1:0] val);
        case (addr)
            CSR_MTVEC:    ref_mtvec    = val;
            CSR_MEPC:     ref_mepc     = val;
            CSR_MCAUSE:   ref_mcause   = val;
            CSR_MSCRATCH: ref_mscratch = val;
            default:      ;
        endcase
    endtask

    task automatic add_entry(input logic [31:0] word, input logic [XLEN-1:0] src,
                             input logic [XLEN-1:0] rs2_val, input logic [31:0] last,
                             input logic [XLEN-1:0] wb_val, input logic trap_val);
        entry_t          e;
        logic [4:0]      opc;
        logic [2:0]      f3;
        int              nbytes;
        logic [XLEN-1:0] data;
        logic [XLEN-1:0] old;
        e           = '0;
        opc         = word[6:2];
        f3          = word[14:12];
        nbytes      = 1 << f3[1:0];
        e.instr     = word;
        e.pc        = next_pc;
        e.alures    = src;
        e.rs2       = rs2_val;
        e.last      = last;
        e.wb_data   = wb_val;
        e.trap      = trap_val;
        e.exp_rd    = (opc == OPC_LOAD);
        e.exp_wr    = (opc == OPC_STORE);
        e.exp_mask  = 8'(((1 << nbytes) - 1) << src[2:0]);
        e.exp_valid = !e.exp_wr;
        e.exp_res   = src;
        if (e.exp_wr) begin
            data = (writes_rd(last[6:2]) && last[11:7] != 5'd0 && last[11:7] == word[24:20])
                 ? wb_val : rs2_val;
            for (int i = 0; i < nbytes; i++) begin
                shadow[src[7:0] + 8'(i)] = data[8*i +: 8];   // Little endian
            end
        end else if (e.exp_rd) begin
            data = '0;
            for (int i = 0; i < nbytes; i++) begin
                data[8*i +: 8] = shadow[src[7:0] + 8'(i)];
            end
            if (!f3[2] && nbytes < 8 && data[8*nbytes-1]) begin
                for (int i = nbytes; i < 8; i++) begin
                    data[8*i +: 8] = 8'hff;
                end
            end
            e.exp_res = data;
        end else if (trap_val) begin
            ref_mepc   = next_pc;
            ref_mcause = TRAP_CAUSE;
        end else if (opc == OPC_SYSTEM && f3 inside {3'd1, 3'd2, 3'd3}) begin
            old       = read_csr(word[31:20]);
            e.exp_csr = old;
            if (f3 == 3'd1) begin
                write_csr(word[31:20], src);
            end else if (word[19:15] != 5'd0) begin
                write_csr(word[31:20], (f3 == 3'd2) ? (old | src) : (old & ~src));
            end
        end
        e.exp_mtvec = ref_mtvec;
        e.exp_mepc  = ref_mepc;
        next_pc     = next_pc + 64'd4;
        table_q.push_back(e);
    endtask

    task automatic add_store(input logic [2:0] f3, input logic [4:0] rs2_reg,
                             input logic [XLEN-1:0] addr, input logic [XLEN-1:0] val,
                             input logic [31:0] last, input logic [XLEN-1:0] wb_val);
        add_entry({7'd0, rs2_reg, 5'd1, f3, 5'd0, OPC_STORE, 2'b11},
                  addr, val, last, wb_val, 1'b0);
    endtask

    task automatic add_load(input logic [2:0] f3, input logic [XLEN-1:0] addr);
        add_entry({12'd0, 5'd1, f3, 5'd10, OPC_LOAD, 2'b11}, addr, '0, NOP, '0, 1'b0);
    endtask

    task automatic add_csr(input logic [2:0] f3, input logic [11:0] csr,
                           input logic [4:0] rs1, input logic [XLEN-1:0] src);
        add_entry({csr, rs1, f3, 5'd10, OPC_SYSTEM, 2'b11}, src, '0, NOP, '0, 1'b0);
    endtask

    // ************************************************************
    // Stimulus table
    // ************************************************************
    task automatic build_table();
        ref_mtvec    = RESET_MTVEC;
        ref_mepc     = '0;
        ref_mcause   = '0;
        ref_mscratch = '0;
        next_pc      = 64'h0000_0000_8000_0100;
        add_store(MEMOP_LD, 5'd5, 64'h1000, 64'hf1e2_d3c4_b5a6_9788, NOP, '0);
        add_store(MEMOP_LW, 5'd5, 64'h100c, 64'h1111_2222_8bad_f00d, NOP, '0);
        add_store(MEMOP_LH, 5'd5, 64'h1012, 64'h3333_4444_5555_8001, NOP, '0);
        add_store(MEMOP_LB, 5'd5, 64'h1017, 64'h0000_0000_0000_0080, NOP, '0);
        add_store(MEMOP_LB, 5'd5, 64'h1010, 64'hffff_ffff_ffff_ff7f, NOP, '0);
        add_load(MEMOP_LD, 64'h1000);
        add_load(MEMOP_LW, 64'h1004);
        add_load(MEMOP_LWU, 64'h1004);
        add_load(MEMOP_LH, 64'h1002);
        add_load(MEMOP_LHU, 64'h1006);
        add_load(MEMOP_LB, 64'h1001);
        add_load(MEMOP_LBU, 64'h1007);
        add_load(MEMOP_LW, 64'h100c);
        add_load(MEMOP_LH, 64'h1012);
        add_load(MEMOP_LHU, 64'h1012);
        add_load(MEMOP_LB, 64'h1017);
        add_load(MEMOP_LBU, 64'h1017);
        add_load(MEMOP_LB, 64'h1010);
        // Write-back forwarding, x0 never forwards
        add_store(MEMOP_LD, 5'd7, 64'h1020, 64'hdead_beef_dead_beef,
                  ADDI_X7, 64'h0123_4567_89ab_cdef);
        add_load(MEMOP_LD, 64'h1020);
        add_store(MEMOP_LW, 5'd0, 64'h1028, 64'h0000_0000_5555_aaaa,
                  NOP, 64'hffff_ffff_ffff_ffff);
        add_load(MEMOP_LWU, 64'h1028);
        add_entry(ADDI_X7, 64'h1234_5678_9abc_def0, '0, NOP, '0, 1'b0);
        add_csr(CSR_OP_RW, CSR_MTVEC, 5'd1, 64'h2000);
        add_csr(CSR_OP_RW, CSR_MSCRATCH, 5'd1, 64'habcd);
        add_csr(CSR_OP_RW, CSR_MEPC, 5'd1, 64'h4444);
        add_csr(CSR_OP_RS, CSR_MTVEC, 5'd1, 64'h3);
        add_csr(CSR_OP_RC, CSR_MTVEC, 5'd1, 64'h2001);
        add_csr(CSR_OP_RS, CSR_MSCRATCH, 5'd0, 64'hffff);
        add_csr(CSR_OP_RC, CSR_MSCRATCH, 5'd2, 64'h00cd);
        add_csr(CSR_OP_RW, CSR_MSCRATCH, 5'd1, '0);
        add_entry(ADDI_X7, 64'h55, '0, NOP, '0, 1'b1);   // Trap
        add_csr(CSR_OP_RS, CSR_MCAUSE, 5'd0, 64'hff);
        add_csr(CSR_OP_RC, CSR_MEPC, 5'd2, 64'h3);
        add_load(MEMOP_LB, 64'h1003);
    endtask

    task automatic apply_entry(input entry_t e);
        logic done;
        done       = 1'b0;
        valid      = 1'b1;
        pc         = e.pc;
        instr      = e.instr;
        alures     = e.alures;
        rs2        = e.rs2;
        instr_last = e.last;
        wb_data    = e.wb_data;
        trap       = e.trap;
        while (!done) begin
            @(negedge clk);
            compare_bit("sram_req_o.rd_en", e.exp_rd, sram_req.rd_en);
            compare_bit("sram_req_o.wr_en", e.exp_wr, sram_req.wr_en);
            if (e.exp_rd || e.exp_wr) begin
                compare_xlen("sram_req_o.addr", {e.alures[XLEN-1:3], 3'b000}, sram_req.addr);
            end
            // Access size is funct3 bits 1 to 0
            if (e.exp_rd) begin
                compare_size("sram_req_o.rd_size", {1'b0, e.instr[13:12]}, sram_req.rd_size);
            end
            if (e.exp_wr) begin
                compare_mask("sram_req_o.wr_mask", e.exp_mask, sram_req.wr_mask);
                compare_size("sram_req_o.wr_size", {1'b0, e.instr[13:12]}, sram_req.wr_size);
            end
            // Stalled until the pending access gets its response
            compare_bit("ls_not_ok_o", (e.exp_rd && !sram_rsp.rd_data_valid)
                        || (e.exp_wr && !sram_rsp.wr_data_ok), ls_not_ok);
            done = !ls_not_ok;
        end
        compare_xlen("csr_data_o", e.exp_csr, csr_data);
        @(posedge clk);
        #1;
        compare_bit("res_valid_o", e.exp_valid, res_valid);
        if (e.exp_valid) begin
            compare_xlen("ls_res_o", e.exp_res, ls_res);
        end
        compare_xlen("mtvec_o", e.exp_mtvec, mtvec);
        compare_xlen("mepc_o", e.exp_mepc, mepc);
        #1;
    endtask

    initial begin
        void'($urandom(32'h4f30_1ddb));
        table_ready = 1'b0;
        arst_n      = 1'b0;
        valid       = 1'b0;
        pc          = '0;
        instr       = '0;
        alures      = '0;
        rs2         = '0;
        instr_last  = '0;
        wb_data     = '0;
        trap        = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        arst_n = 1'b1;
        @(negedge clk);
        compare_xlen("mtvec_o", RESET_MTVEC, mtvec);
        compare_bit("res_valid_o", 1'b0, res_valid);
        compare_bit("ls_not_ok_o", 1'b0, ls_not_ok);
        @(posedge clk);
        #2;
        foreach (table_q[k]) begin
            apply_entry(table_q[k]);
        end
        valid = 1'b0;
        $display("sim passed");
        $finish;
    end

    // Watchdog
    initial begin
        wait (table_ready);
        repeat (10 * table_q.size() + 50) @(posedge clk);
        $display("timeout: stage never completed");
        $display("sim failed");
        $fatal(1);
    end

endmodule

//--- flist.f
rv_ls_pkg.sv
ls_ctr.sv
lsu.sv
csr_unit.sv
ls_stage.sv
tb_sram_model.sv
tb_ls_stage.sv

//--- run.sh
#!/bin/sh
# Build and run the load/store stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
    --timescale 1ns/100ps \
    --top-module tb_ls_stage \
    -f flist.f \
    -o tb_ls_stage

# A failing run ends in $fatal and returns a nonzero status
./obj_dir/tb_ls_stage
